// ==== src/bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    // table sizes
    localparam int BIMODAL_ENTRIES = 512;
    localparam int BTB_ENTRIES     = 256;

    // index and tag widths, tied to fixed pc bit fields
    localparam int BIMODAL_IDX_W = 9;   // pc[9:1]
    localparam int BTB_IDX_W     = 8;   // pc[9:2]
    localparam int BTB_TAG_W     = 22;  // pc[31:10]

    // counter reset value, weakly not taken
    localparam logic [1:0] CTR_INIT = 2'd1;

    // bimodal counter index
    typedef logic [BIMODAL_IDX_W-1:0] bimodal_idx_t;

    // btb set index
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;

    // btb tag, upper pc bits
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    // 2-bit saturating counter
    // 0 strong not taken .. 3 strong taken
    typedef logic [1:0] ctr_t;

endpackage

// ==== src/rv_inst_pkg.sv ====
package rv_inst_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;   // pc or branch target
    typedef logic [31:0]     inst_t;   // raw instruction word
    typedef logic [6:0]      opcode_t; // major opcode, inst[6:0]

    // control transfer opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // instruction kind as seen by the predictor
    typedef logic [1:0] kind_t;

    localparam kind_t KIND_NONE = 2'd0; // not a control transfer
    localparam kind_t KIND_COND = 2'd1; // conditional branch
    localparam kind_t KIND_JAL  = 2'd2;
    localparam kind_t KIND_JALR = 2'd3; // includes ret

endpackage

// ==== src/bimodal_table.sv ====
`timescale 1ns/1ps

module bimodal_table (
    input  logic                      clk,
    input  logic                      rst,
    input  bpu_cfg_pkg::bimodal_idx_t rd_idx_i,
    input  logic                      upd_valid_i,
    input  rv_inst_pkg::addr_t        upd_pc_i,
    input  logic                      upd_taken_i,
    output bpu_cfg_pkg::ctr_t         rd_ctr_o
);

    bpu_cfg_pkg::ctr_t         ctr_mem [bpu_cfg_pkg::BIMODAL_ENTRIES];
    bpu_cfg_pkg::bimodal_idx_t upd_idx;
    bpu_cfg_pkg::ctr_t         upd_ctr;

    assign upd_idx = upd_pc_i[bpu_cfg_pkg::BIMODAL_IDX_W:1]; // same field as the lookup side
    assign upd_ctr = ctr_mem[upd_idx];

    // combinational read
    assign rd_ctr_o = ctr_mem[rd_idx_i];

    // flop counters, all start weakly not taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_cfg_pkg::BIMODAL_ENTRIES; i++) begin
                ctr_mem[i] <= bpu_cfg_pkg::CTR_INIT;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                if (upd_ctr != 2'd3) begin   // saturate high
                    ctr_mem[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'd0) begin   // saturate low
                    ctr_mem[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// ==== src/btb.sv ====
`timescale 1ns/1ps

module btb (
    input  logic                  clk,
    input  logic                  rst,
    input  bpu_cfg_pkg::btb_idx_t rd_idx_i,
    input  bpu_cfg_pkg::btb_tag_t rd_tag_i,
    input  logic                  upd_valid_i,
    input  rv_inst_pkg::addr_t    upd_pc_i,
    input  logic                  upd_taken_i,
    input  rv_inst_pkg::addr_t    upd_target_i,
    output logic                  hit_o,
    output rv_inst_pkg::addr_t    target_o
);

    bpu_cfg_pkg::btb_tag_t          tag_mem    [bpu_cfg_pkg::BTB_ENTRIES];
    rv_inst_pkg::addr_t             target_mem [bpu_cfg_pkg::BTB_ENTRIES];
    logic [bpu_cfg_pkg::BTB_ENTRIES-1:0] valid_q;

    bpu_cfg_pkg::btb_idx_t upd_idx;
    bpu_cfg_pkg::btb_tag_t upd_tag;
    logic                  wr_en;

    assign upd_idx = upd_pc_i[bpu_cfg_pkg::BTB_IDX_W+1:2];
    assign upd_tag = upd_pc_i[rv_inst_pkg::XLEN-1:rv_inst_pkg::XLEN-bpu_cfg_pkg::BTB_TAG_W];

    // only taken branches allocate
    assign wr_en = upd_valid_i && upd_taken_i;

    // lookup
    assign hit_o    = valid_q[rd_idx_i] && (tag_mem[rd_idx_i] == rd_tag_i);
    assign target_o = target_mem[rd_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // direct mapped, a new tag simply replaces the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd_target_i;
        end
    end

endmodule

// ==== src/bpu_decode_stage.sv ====
`timescale 1ns/1ps

module bpu_decode_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid_i,
    input  rv_inst_pkg::addr_t         req_pc_i,
    input  rv_inst_pkg::inst_t         req_inst_i,
    input  logic                       s2_ready_i,
    output logic                       req_ready_o,
    output logic                       s1_valid_o,
    output rv_inst_pkg::addr_t         s1_pc_o,
    output rv_inst_pkg::kind_t         s1_kind_o,
    output rv_inst_pkg::addr_t         s1_imm_target_o,
    output bpu_cfg_pkg::bimodal_idx_t  s1_bm_idx_o,
    output bpu_cfg_pkg::btb_idx_t      s1_btb_idx_o,
    output bpu_cfg_pkg::btb_tag_t      s1_btb_tag_o
);

    rv_inst_pkg::opcode_t opcode;
    rv_inst_pkg::kind_t   kind;
    rv_inst_pkg::addr_t   b_imm;
    rv_inst_pkg::addr_t   j_imm;
    rv_inst_pkg::addr_t   imm_target;
    logic                 accept;

    assign opcode = req_inst_i[6:0];

    // sign extended immediates
    assign b_imm = {{20{req_inst_i[31]}}, req_inst_i[7], req_inst_i[30:25],
                    req_inst_i[11:8], 1'b0};
    assign j_imm = {{12{req_inst_i[31]}}, req_inst_i[19:12], req_inst_i[20],
                    req_inst_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            rv_inst_pkg::OPC_BRANCH: kind = rv_inst_pkg::KIND_COND;
            rv_inst_pkg::OPC_JAL:    kind = rv_inst_pkg::KIND_JAL;
            rv_inst_pkg::OPC_JALR:   kind = rv_inst_pkg::KIND_JALR; // ret handled the same way
            default:                 kind = rv_inst_pkg::KIND_NONE;
        endcase
    end

    // jalr target depends on rs1, so only pc+4 is known here
    always_comb begin
        case (kind)
            rv_inst_pkg::KIND_COND: imm_target = req_pc_i + b_imm;
            rv_inst_pkg::KIND_JAL:  imm_target = req_pc_i + j_imm;
            default:                imm_target = req_pc_i + 32'd4;
        endcase
    end

    // one entry stage, may refill in the cycle it drains
    assign req_ready_o = !s1_valid_o || s2_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            s1_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_pc_o         <= req_pc_i;
            s1_kind_o       <= kind;
            s1_imm_target_o <= imm_target;
            s1_bm_idx_o     <= req_pc_i[bpu_cfg_pkg::BIMODAL_IDX_W:1];
            s1_btb_idx_o    <= req_pc_i[bpu_cfg_pkg::BTB_IDX_W+1:2];
            s1_btb_tag_o    <= req_pc_i[rv_inst_pkg::XLEN-1:rv_inst_pkg::XLEN-bpu_cfg_pkg::BTB_TAG_W];
        end
    end

endmodule

// ==== src/bpu_lookup_stage.sv ====
`timescale 1ns/1ps

module bpu_lookup_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s1_valid_i,
    input  rv_inst_pkg::addr_t        s1_pc_i,
    input  rv_inst_pkg::kind_t        s1_kind_i,
    input  rv_inst_pkg::addr_t        s1_imm_target_i,
    input  bpu_cfg_pkg::bimodal_idx_t s1_bm_idx_i,
    input  bpu_cfg_pkg::btb_idx_t     s1_btb_idx_i,
    input  bpu_cfg_pkg::btb_tag_t     s1_btb_tag_i,
    input  logic                      resp_ready_i,
    input  logic                      upd_valid_i,
    input  rv_inst_pkg::addr_t        upd_pc_i,
    input  logic                      upd_taken_i,
    input  rv_inst_pkg::addr_t        upd_target_i,
    output logic                      s2_ready_o,
    output logic                      resp_valid_o,
    output logic                      resp_is_branch_o,
    output logic                      resp_taken_o,
    output rv_inst_pkg::addr_t        resp_target_o
);

    bpu_cfg_pkg::ctr_t  bm_ctr;
    logic               btb_hit;
    rv_inst_pkg::addr_t btb_target;
    rv_inst_pkg::addr_t pc_plus4;
    rv_inst_pkg::addr_t taken_target;
    logic               pred_is_branch;
    logic               pred_taken;
    rv_inst_pkg::addr_t pred_target;

    bimodal_table i_bimodal (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_i    (s1_bm_idx_i),
        .upd_valid_i (upd_valid_i),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i),
        .rd_ctr_o    (bm_ctr)
    );

    btb i_btb (
        .clk          (clk),
        .rst          (rst),
        .rd_idx_i     (s1_btb_idx_i),
        .rd_tag_i     (s1_btb_tag_i),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .upd_target_i (upd_target_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target)
    );

    assign pc_plus4     = s1_pc_i + 32'd4;
    assign taken_target = btb_hit ? btb_target : s1_imm_target_i; // btb wins over the immediate

    always_comb begin
        pred_is_branch = 1'b1;
        pred_taken     = 1'b0;
        pred_target    = pc_plus4;
        case (s1_kind_i)
            rv_inst_pkg::KIND_NONE: pred_is_branch = 1'b0;
            rv_inst_pkg::KIND_JAL: begin
                pred_taken  = 1'b1; // always taken
                pred_target = taken_target;
            end
            rv_inst_pkg::KIND_COND, rv_inst_pkg::KIND_JALR: begin
                pred_taken = bm_ctr[1]; // counter msb gives direction
                if (bm_ctr[1]) begin
                    pred_target = taken_target;
                end
            end
        endcase
    end

    // output register holds until consumed
    assign s2_ready_o = !resp_valid_o || resp_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else if (s2_ready_o) begin
            resp_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_i && s2_ready_o) begin
            resp_is_branch_o <= pred_is_branch;
            resp_taken_o     <= pred_taken;
            resp_target_o    <= pred_target;
        end
    end

endmodule

// ==== src/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top (
    input  logic               clk,
    input  logic               rst,
    // fetch request
    input  logic               req_valid_i,
    input  rv_inst_pkg::addr_t req_pc_i,
    input  rv_inst_pkg::inst_t req_inst_i,
    output logic               req_ready_o,
    // prediction response
    output logic               resp_valid_o,
    output logic               resp_is_branch_o,
    output logic               resp_taken_o,
    output rv_inst_pkg::addr_t resp_target_o,
    input  logic               resp_ready_i,
    // training from execute
    input  logic               upd_valid_i,
    input  rv_inst_pkg::addr_t upd_pc_i,
    input  logic               upd_taken_i,
    input  rv_inst_pkg::addr_t upd_target_i
);

    logic                      s1_valid;
    rv_inst_pkg::addr_t        s1_pc;
    rv_inst_pkg::kind_t        s1_kind;
    rv_inst_pkg::addr_t        s1_imm_target;
    bpu_cfg_pkg::bimodal_idx_t s1_bm_idx;
    bpu_cfg_pkg::btb_idx_t     s1_btb_idx;
    bpu_cfg_pkg::btb_tag_t     s1_btb_tag;
    logic                      s2_ready;

    bpu_decode_stage i_decode (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_pc_i        (req_pc_i),
        .req_inst_i      (req_inst_i),
        .s2_ready_i      (s2_ready),
        .req_ready_o     (req_ready_o),
        .s1_valid_o      (s1_valid),
        .s1_pc_o         (s1_pc),
        .s1_kind_o       (s1_kind),
        .s1_imm_target_o (s1_imm_target),
        .s1_bm_idx_o     (s1_bm_idx),
        .s1_btb_idx_o    (s1_btb_idx),
        .s1_btb_tag_o    (s1_btb_tag)
    );

    bpu_lookup_stage i_lookup (
        .clk              (clk),
        .rst              (rst),
        .s1_valid_i       (s1_valid),
        .s1_pc_i          (s1_pc),
        .s1_kind_i        (s1_kind),
        .s1_imm_target_i  (s1_imm_target),
        .s1_bm_idx_i      (s1_bm_idx),
        .s1_btb_idx_i     (s1_btb_idx),
        .s1_btb_tag_i     (s1_btb_tag),
        .resp_ready_i     (resp_ready_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_taken_i      (upd_taken_i),
        .upd_target_i     (upd_target_i),
        .s2_ready_o       (s2_ready),
        .resp_valid_o     (resp_valid_o),
        .resp_is_branch_o (resp_is_branch_o),
        .resp_taken_o     (resp_taken_o),
        .resp_target_o    (resp_target_o)
    );

endmodule

// ==== test/bpu_ref_model.svh ====
`ifndef BPU_REF_MODEL_SVH
`define BPU_REF_MODEL_SVH

// model copy of the predictor state
bpu_cfg_pkg::ctr_t     m_ctr    [bpu_cfg_pkg::BIMODAL_ENTRIES];
logic                  m_valid  [bpu_cfg_pkg::BTB_ENTRIES];
bpu_cfg_pkg::btb_tag_t m_tag    [bpu_cfg_pkg::BTB_ENTRIES];
rv_inst_pkg::addr_t    m_target [bpu_cfg_pkg::BTB_ENTRIES];

task automatic model_reset();
    foreach (m_ctr[i]) m_ctr[i] = bpu_cfg_pkg::CTR_INIT;
    foreach (m_valid[i]) m_valid[i] = 1'b0;
endtask

// expected {is_branch, taken, target} for one fetch
function automatic logic [33:0] predict(input rv_inst_pkg::addr_t pc, input rv_inst_pkg::inst_t inst);
    logic signed [12:0] b_off;
    logic signed [20:0] j_off;
    rv_inst_pkg::addr_t fall;
    logic               hit;
    logic               dir;
    b_off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    j_off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    fall  = pc + 32'd4;
    hit   = m_valid[pc[9:2]] && (m_tag[pc[9:2]] == pc[31:10]);
    dir   = m_ctr[pc[9:1]][1];    // upper counter bit
    case (inst[6:0])
        rv_inst_pkg::OPC_BRANCH:
            return {1'b1, dir, !dir ? fall : (hit ? m_target[pc[9:2]] : pc + 32'(b_off))};
        rv_inst_pkg::OPC_JAL:
            return {1'b1, 1'b1, hit ? m_target[pc[9:2]] : pc + 32'(j_off)};
        rv_inst_pkg::OPC_JALR:
            return {1'b1, dir, (dir && hit) ? m_target[pc[9:2]] : fall}; // no rs1, so pc+4
        default:
            return {1'b0, 1'b0, fall};
    endcase
endfunction

task automatic model_update(input rv_inst_pkg::addr_t pc, input logic taken,
                            input rv_inst_pkg::addr_t target);
    if (taken && m_ctr[pc[9:1]] != 2'd3) begin
        m_ctr[pc[9:1]] = m_ctr[pc[9:1]] + 2'd1;
    end else if (!taken && m_ctr[pc[9:1]] != 2'd0) begin
        m_ctr[pc[9:1]] = m_ctr[pc[9:1]] - 2'd1;
    end
    if (taken) begin
        m_valid[pc[9:2]]  = 1'b1;
        m_tag[pc[9:2]]    = pc[31:10];
        m_target[pc[9:2]] = target;
    end
endtask

`endif

// ==== test/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb;

    localparam int NUM_BURST  = 32;
    localparam int NUM_BP     = 64;
    localparam int NUM_ROUNDS = 8;
    localparam int ROUND_LEN  = 16;   // updates, then requests, per round
    // directed part stays under 100 cycles, back-pressure about halves the rate
    localparam int MAX_CYCLES = 4 * (100 + NUM_BURST + 2 * NUM_BP
                                     + NUM_ROUNDS * (2 * ROUND_LEN + 4));

    logic               clk;
    logic               rst;
    logic               req_valid_i;
    rv_inst_pkg::addr_t req_pc_i;
    rv_inst_pkg::inst_t req_inst_i;
    logic               req_ready_o;
    logic               resp_valid_o;
    logic               resp_is_branch_o;
    logic               resp_taken_o;
    rv_inst_pkg::addr_t resp_target_o;
    logic               resp_ready_i;
    logic               upd_valid_i;
    rv_inst_pkg::addr_t upd_pc_i;
    logic               upd_taken_i;
    rv_inst_pkg::addr_t upd_target_i;

    int          seed;
    int          cycle = 0;
    int          err_count;
    int          err_mark;
    int          pass_tests;
    int          fail_tests;
    int          req_count;
    int          resp_count;
    int          last_acc;
    int          acc_cycle;
    logic        bp_mode;
    logic        check_latency;
    logic [63:0] ready_bits;
    logic [33:0] exp_resp;
    logic [33:0] exp_q [$];   // {is_branch, taken, target}
    int          acc_q [$];   // acceptance cycle per request

    `include "bpu_ref_model.svh"

    bpu_top i_dut (.*);

    task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
        err_count++;
    endtask

    function automatic rv_inst_pkg::inst_t enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], rv_inst_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_inst_pkg::inst_t enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, rv_inst_pkg::OPC_JAL};
    endfunction

    // small pc pool with two tags per btb index, so entries get reused
    function automatic rv_inst_pkg::addr_t rand_pc();
        logic [31:0] r;
        r = $random(seed);
        return r & 32'h0010_00fe;
    endfunction

    function automatic rv_inst_pkg::inst_t rand_inst();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    return enc_branch(r[14:2]);
            2'd1:    return enc_jal(r[22:2]);
            2'd2:    return 32'h0000_8067;   // ret
            default: return 32'h0000_0013;   // nop
        endcase
    endfunction

    // called at a falling edge, returns at the falling edge after acceptance
    task automatic send_req(input rv_inst_pkg::addr_t pc, input rv_inst_pkg::inst_t inst);
        req_valid_i = 1'b1;
        req_pc_i    = pc;
        req_inst_i  = inst;
        @(posedge clk);
        while (!req_ready_o) @(posedge clk);
        exp_q.push_back(predict(pc, inst));
        acc_q.push_back(cycle);
        last_acc = cycle;
        req_count++;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic send_upd(input rv_inst_pkg::addr_t pc, input logic taken,
                            input rv_inst_pkg::addr_t target);
        while (exp_q.size() != 0) @(negedge clk);   // train only with nothing in flight
        upd_valid_i  = 1'b1;
        upd_pc_i     = pc;
        upd_taken_i  = taken;
        upd_target_i = target;
        @(negedge clk);
        upd_valid_i = 1'b0;
        model_update(pc, taken, target);
    endtask

    task automatic rand_update();
        logic [31:0] r;
        r = $random(seed);
        send_upd(rand_pc(), r[0], rand_pc());
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(negedge clk);
        assert (resp_count == req_count)
            else show_mismatch("response count", req_count, resp_count);
        if (err_count == err_mark) begin
            pass_tests++;
            $display("%s: passed", name);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random stall pattern while bp_mode is set
    initial begin
        resp_ready_i = 1'b1;
        forever begin
            @(negedge clk);
            resp_ready_i = bp_mode ? ready_bits[cycle[5:0]] : 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // compare each consumed response with the oldest expected one
    always @(posedge clk) begin
        if (!rst && resp_valid_o && resp_ready_i) begin
            resp_count++;
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: response arrived with no request outstanding", $time);
                err_count++;
            end else begin
                exp_resp  = exp_q.pop_front();
                acc_cycle = acc_q.pop_front();
                assert (resp_is_branch_o === exp_resp[33])
                    else show_mismatch("resp_is_branch_o", 32'(exp_resp[33]), 32'(resp_is_branch_o));
                assert (resp_taken_o === exp_resp[32])
                    else show_mismatch("resp_taken_o", 32'(exp_resp[32]), 32'(resp_taken_o));
                assert (resp_target_o === exp_resp[31:0])
                    else show_mismatch("resp_target_o", exp_resp[31:0], resp_target_o);
                if (check_latency) begin
                    assert (cycle - acc_cycle == 2)
                        else show_mismatch("response latency", 2, cycle - acc_cycle);
                end
            end
        end
    end

    initial begin
        int t0;
        seed          = 83299;
        err_count     = 0;
        err_mark      = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        req_count     = 0;
        resp_count    = 0;
        bp_mode       = 1'b0;
        check_latency = 1'b0;
        ready_bits    = '1;
        rst           = 1'b1;
        req_valid_i   = 1'b0;
        req_pc_i      = '0;
        req_inst_i    = '0;
        upd_valid_i   = 1'b0;
        upd_pc_i      = '0;
        upd_taken_i   = 1'b0;
        upd_target_i  = '0;
        model_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_req(32'h0000_1000, enc_branch(13'h0020));
        send_req(32'h0000_1004, 32'h0000_8067);
        send_req(32'h0000_1008, enc_jal(21'h1f_fff0));   // backward jump
        send_req(32'h0000_100c, 32'h0000_0013);
        end_test("test 1 reset state");

        // strongly taken after two, saturate, then back to not taken
        repeat (2) send_upd(32'h0000_2040, 1'b1, 32'h0000_2080);
        send_req(32'h0000_2040, enc_branch(13'h0040));
        repeat (2) send_upd(32'h0000_2040, 1'b1, 32'h0000_2080);   // a wrapping counter drops msb
        send_req(32'h0000_2040, enc_branch(13'h0040));
        repeat (2) send_upd(32'h0000_2040, 1'b0, 32'h0000_0000);
        send_req(32'h0000_2040, enc_branch(13'h0040));
        end_test("test 2 counter training");

        send_upd(32'h0000_3100, 1'b1, 32'h0008_0000);
        send_req(32'h0000_3100, enc_branch(13'h0100));
        send_req(32'h0000_3100, enc_jal(21'h00_0200));
        send_req(32'h0000_3500, enc_branch(13'h0100));   // same index, other tag
        send_req(32'h0000_3500, enc_jal(21'h00_0200));
        end_test("test 3 btb");

        check_latency = 1'b1;
        send_req(rand_pc(), rand_inst());
        t0 = last_acc;
        repeat (NUM_BURST - 1) send_req(rand_pc(), rand_inst());
        assert (last_acc - t0 == NUM_BURST - 1)
            else show_mismatch("accept cycles", NUM_BURST - 1, last_acc - t0);
        end_test("test 4 throughput");
        check_latency = 1'b0;

        ready_bits = {$random(seed), $random(seed)};
        bp_mode    = 1'b1;
        repeat (NUM_BP) send_req(rand_pc(), rand_inst());
        bp_mode = 1'b0;
        end_test("test 5 back-pressure");

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            repeat (ROUND_LEN) rand_update();
            repeat (ROUND_LEN) send_req(rand_pc(), rand_inst());
        end
        end_test("test 6 random mix");

        $display("tests passed %0d, failed %0d, responses %0d", pass_tests, fail_tests, resp_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+test
src/bpu_cfg_pkg.sv
src/rv_inst_pkg.sv
src/bimodal_table.sv
src/btb.sv
src/bpu_decode_stage.sv
src/bpu_lookup_stage.sv
src/bpu_top.sv
test/bpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the predictor testbench with verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module bpu_tb -f build.f -o bpu_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/bpu_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
